// ==== design/access_ctrl.sv ====
// Fixed priority arbiter for download writes and game banks, response demux
`timescale 1ns/1ns

module access_ctrl
    import frame_pkg::*;
(
    input  logic                         clk_sys,
    input  logic                         RESET,
    input  logic [BANK_COUNT-1:0]        pending,
    input  rw_req_t                      bank0_payload,
    input  rd_req_t [BANK_COUNT-2:0]     rd_payload,
    input  logic                         downloading,
    input  logic                         prog_we,
    input  logic [ADDR_W-1:0]            prog_addr,
    input  logic [BANK_W-1:0]            prog_ba,
    input  logic [DATA_W-1:0]            prog_data,
    input  logic [MASK_W-1:0]            prog_mask,
    input  mem_rsp_t                     rsp,
    output logic [BANK_COUNT-1:0]        grant,
    output mem_cmd_t                     cmd,
    output logic [BANK_COUNT-1:0]        bank_rdy,
    output logic                         prog_rdy,
    output logic [DATA_W-1:0]            sdram_dout
);

    logic              prog_busy;
    logic              prog_issue;
    logic [BANK_W-1:0] grant_idx;

    // One download write in flight until its done pulse is over
    assign prog_issue = downloading && prog_we && !prog_busy && !prog_rdy;

    ////////////////////////////////////////
    // Bank arbitration
    ////////////////////////////////////////
    always_comb begin
        grant     = '0;
        grant_idx = '0;
        if (!downloading) begin
            // Lowest pending bank wins
            for (int i = BANK_COUNT - 1; i >= 0; i--) begin
                if (pending[i]) begin
                    grant     = '0;
                    grant[i]  = 1'b1;
                    grant_idx = BANK_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            cmd <= '0;
        end else if (prog_issue) begin
            cmd <= '{valid: 1'b1, bank: prog_ba, addr: prog_addr, we: 1'b1,
                     data: prog_data, mask: prog_mask, game: 1'b0};
        end else if (|grant) begin
            if (grant_idx == '0) begin
                cmd <= '{valid: 1'b1, bank: grant_idx, addr: bank0_payload.addr,
                         we: bank0_payload.we, data: bank0_payload.din,
                         mask: bank0_payload.din_m, game: 1'b1};
            end else begin
                cmd <= '{valid: 1'b1, bank: grant_idx, addr: rd_payload[grant_idx - 2'd1].addr,
                         we: 1'b0, data: '0, mask: '0, game: 1'b1};
            end
        end else begin
            cmd.valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Responses
    ////////////////////////////////////////
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            bank_rdy  <= '0;
            prog_rdy  <= 1'b0;
            prog_busy <= 1'b0;
        end else begin
            bank_rdy <= '0;
            prog_rdy <= 1'b0;
            if (prog_issue) begin
                prog_busy <= 1'b1;
            end
            if (rsp.valid && rsp.game) begin
                bank_rdy[rsp.bank] <= 1'b1;
            end else if (rsp.valid) begin
                prog_rdy  <= 1'b1;
                prog_busy <= 1'b0;
            end
        end
    end

    // Shared return bus valid with the rdy pulse
    always_ff @(posedge clk_sys) begin
        if (rsp.valid) begin
            sdram_dout <= rsp.data;
        end
    end

endmodule

// ==== design/bank_slot.sv ====
// Single pending request holder with grant driven acknowledge
`timescale 1ns/1ns

module bank_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk_sys,
    input  logic     RESET,
    input  logic     req,
    input  payload_t req_payload,
    input  logic     grant,
    output logic     pending,
    output payload_t payload,
    output logic     ack
);

    logic capture;
    logic granted;

    // No new capture during the ack pulse while req is still held
    assign capture = req && !pending && !ack;
    assign granted = pending && grant;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            pending <= 1'b0;
            ack     <= 1'b0;
        end else begin
            ack <= granted;
            if (granted) begin
                pending <= 1'b0;
            end else if (capture) begin
                pending <= 1'b1;
            end
        end
    end

    // Request fields held until the grant
    always_ff @(posedge clk_sys) begin
        if (capture) begin
            payload <= req_payload;
        end
    end

endmodule

// ==== design/frame_pkg.sv ====
// Widths, counts and the request, command and response structs of the memory core
package frame_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int BANK_COUNT       = 4;
    localparam int BANK_W           = 2;
    localparam int ADDR_W           = 22;
    localparam int DATA_W           = 16;
    localparam int MASK_W           = 2;

    // Store keeps 256 words per bank and upper address bits alias
    localparam int STORE_AW         = 8;
    localparam int STORE_LATENCY    = 2;

    // PLL reset stretch after a lock loss
    localparam int LOCK_HOLD_CYCLES = 256;

    ////////////////////////////////////////
    // Game side requests
    ////////////////////////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    // Bank 0 can read or write
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] din;
        logic [MASK_W-1:0] din_m;
    } rw_req_t;

    ////////////////////////////////////////
    // Store command and response
    ////////////////////////////////////////
    typedef struct packed {
        logic              valid;
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] data;
        logic [MASK_W-1:0] mask;
        logic              game;
    } mem_cmd_t;

    typedef struct packed {
        logic              valid;
        logic [BANK_W-1:0] bank;
        logic              game;
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

endpackage

// ==== design/frame_top.sv ====
// Memory access core top with bank slots, arbiter, store and reset supervisor
`timescale 1ns/1ns

module frame_top
    import frame_pkg::*;
(
    input  logic              clk_sys,
    input  logic              RESET,
    input  logic              pll_locked,
    input  logic              rst_req,
    input  logic              downloading,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [BANK_W-1:0] prog_ba,
    input  logic [DATA_W-1:0] prog_data,
    input  logic [MASK_W-1:0] prog_mask,
    input  logic              ba0_rd,
    input  logic              ba0_wr,
    input  logic [ADDR_W-1:0] ba0_addr,
    input  logic [DATA_W-1:0] ba0_din,
    input  logic [MASK_W-1:0] ba0_din_m,
    input  logic              ba1_rd,
    input  logic [ADDR_W-1:0] ba1_addr,
    input  logic              ba2_rd,
    input  logic [ADDR_W-1:0] ba2_addr,
    input  logic              ba3_rd,
    input  logic [ADDR_W-1:0] ba3_addr,
    output logic              pll_rst,
    output logic              game_rst,
    output logic              prog_rdy,
    output logic              ba0_ack,
    output logic              ba1_ack,
    output logic              ba2_ack,
    output logic              ba3_ack,
    output logic              ba0_rdy,
    output logic              ba1_rdy,
    output logic              ba2_rdy,
    output logic              ba3_rdy,
    output logic [DATA_W-1:0] sdram_dout
);

    logic [BANK_COUNT-1:0]    pending;
    logic [BANK_COUNT-1:0]    grant;
    logic [BANK_COUNT-1:0]    bank_rdy;
    rw_req_t                  bank0_payload;
    rd_req_t [BANK_COUNT-2:0] rd_payload;
    mem_cmd_t                 cmd;
    mem_rsp_t                 rsp;

    ////////////////////////////////////////
    // Game bank slots
    ////////////////////////////////////////
    bank_slot #(.payload_t(rw_req_t)) u_slot0 (
        .clk_sys     (clk_sys),
        .RESET       (RESET),
        .req         (ba0_rd | ba0_wr),
        .req_payload ('{addr: ba0_addr, we: ba0_wr, din: ba0_din, din_m: ba0_din_m}),
        .grant       (grant[0]),
        .pending     (pending[0]),
        .payload     (bank0_payload),
        .ack         (ba0_ack)
    );

    bank_slot #(.payload_t(rd_req_t)) u_slot1 (
        .clk_sys     (clk_sys),
        .RESET       (RESET),
        .req         (ba1_rd),
        .req_payload ('{addr: ba1_addr}),
        .grant       (grant[1]),
        .pending     (pending[1]),
        .payload     (rd_payload[0]),
        .ack         (ba1_ack)
    );

    bank_slot #(.payload_t(rd_req_t)) u_slot2 (
        .clk_sys     (clk_sys),
        .RESET       (RESET),
        .req         (ba2_rd),
        .req_payload ('{addr: ba2_addr}),
        .grant       (grant[2]),
        .pending     (pending[2]),
        .payload     (rd_payload[1]),
        .ack         (ba2_ack)
    );

    bank_slot #(.payload_t(rd_req_t)) u_slot3 (
        .clk_sys     (clk_sys),
        .RESET       (RESET),
        .req         (ba3_rd),
        .req_payload ('{addr: ba3_addr}),
        .grant       (grant[3]),
        .pending     (pending[3]),
        .payload     (rd_payload[2]),
        .ack         (ba3_ack)
    );

    ////////////////////////////////////////
    // Arbiter and store
    ////////////////////////////////////////
    access_ctrl u_access_ctrl (
        .clk_sys       (clk_sys),
        .RESET         (RESET),
        .pending       (pending),
        .bank0_payload (bank0_payload),
        .rd_payload    (rd_payload),
        .downloading   (downloading),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_ba       (prog_ba),
        .prog_data     (prog_data),
        .prog_mask     (prog_mask),
        .rsp           (rsp),
        .grant         (grant),
        .cmd           (cmd),
        .bank_rdy      (bank_rdy),
        .prog_rdy      (prog_rdy),
        .sdram_dout    (sdram_dout)
    );

    rom_store u_rom_store (
        .clk_sys (clk_sys),
        .RESET   (RESET),
        .cmd     (cmd),
        .rsp     (rsp)
    );

    assign ba0_rdy = bank_rdy[0];
    assign ba1_rdy = bank_rdy[1];
    assign ba2_rdy = bank_rdy[2];
    assign ba3_rdy = bank_rdy[3];

    // Reset sources
    pll_supervisor u_pll_supervisor (
        .clk_sys    (clk_sys),
        .RESET      (RESET),
        .pll_locked (pll_locked),
        .rst_req    (rst_req),
        .pll_rst    (pll_rst),
        .game_rst   (game_rst)
    );

endmodule

// ==== design/pll_supervisor.sv ====
// PLL lock loss detector, PLL reset stretcher and game reset combiner
`timescale 1ns/1ns

module pll_supervisor
    import frame_pkg::*;
(
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    input  logic rst_req,
    output logic pll_rst,
    output logic game_rst
);

    logic                                last_locked;
    logic [$clog2(LOCK_HOLD_CYCLES)-1:0] hold_cnt;

    ////////////////////////////////////////
    // Lock loss stretch
    ////////////////////////////////////////
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            last_locked <= 1'b0;
            pll_rst     <= 1'b0;
            hold_cnt    <= '0;
        end else begin
            last_locked <= pll_locked;
            if (last_locked && !pll_locked) begin
                // Falling lock restarts the full hold
                pll_rst  <= 1'b1;
                hold_cnt <= $bits(hold_cnt)'(LOCK_HOLD_CYCLES - 1);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end else begin
                pll_rst <= 1'b0;
            end
        end
    end

    // Game held in reset while any source is active or the clock is unlocked
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            game_rst <= 1'b1;
        end else begin
            game_rst <= rst_req || pll_rst || !pll_locked;
        end
    end

endmodule

// ==== design/rom_store.sv ====
// Banked word store with byte masked writes and a fixed latency response pipe
`timescale 1ns/1ns

module rom_store
    import frame_pkg::*;
(
    input  logic     clk_sys,
    input  logic     RESET,
    input  mem_cmd_t cmd,
    output mem_rsp_t rsp
);

    logic [DATA_W-1:0]          mem [BANK_COUNT << STORE_AW];
    logic [BANK_W+STORE_AW-1:0] word_idx;
    logic [DATA_W-1:0]          old_word;
    logic [DATA_W-1:0]          new_word;
    mem_rsp_t                   pipe [STORE_LATENCY];

    assign word_idx = {cmd.bank, cmd.addr[STORE_AW-1:0]};
    assign old_word = mem[word_idx];

    // Set mask bit keeps the stored byte
    always_comb begin
        for (int b = 0; b < MASK_W; b++) begin
            new_word[b*8 +: 8] = cmd.mask[b] ? old_word[b*8 +: 8] : cmd.data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cmd.valid && cmd.we) begin
            mem[word_idx] <= new_word;
        end
    end

    ////////////////////////////////////////
    // Response pipe where writes echo the merged word
    ////////////////////////////////////////
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            for (int s = 0; s < STORE_LATENCY; s++) begin
                pipe[s] <= '0;
            end
        end else begin
            pipe[0] <= '{valid: cmd.valid, bank: cmd.bank, game: cmd.game,
                         data: cmd.we ? new_word : old_word};
            for (int s = 1; s < STORE_LATENCY; s++) begin
                pipe[s] <= pipe[s-1];
            end
        end
    end

    assign rsp = pipe[STORE_LATENCY-1];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module frame_tb -f verilog.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vframe_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "all tests passed" <<< "$sim_out"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== sim/frame_checker.sv ====
// Bound assertions on ack and rdy pulses, download blocking and PLL reset length
`timescale 1ns/1ns

module frame_checker
    import frame_pkg::*;
(
    input logic                  clk_sys,
    input logic                  RESET,
    input logic                  downloading,
    input logic [BANK_COUNT-1:0] ack,
    input logic [BANK_COUNT-1:0] rdy,
    input logic                  prog_rdy,
    input logic                  pll_rst
);

    logic [$clog2(LOCK_HOLD_CYCLES):0] hold_len;

    // Cycles pll_rst has been seen high
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            hold_len <= '0;
        end else if (pll_rst) begin
            hold_len <= hold_len + 1'b1;
        end else begin
            hold_len <= '0;
        end
    end

    ////////////////////////////////////////
    // Handshake pulses
    ////////////////////////////////////////
    for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
        assert property (@(posedge clk_sys) disable iff (RESET) ack[i] |=> !ack[i])
            else $error("Bank ack held longer than one cycle");
        assert property (@(posedge clk_sys) disable iff (RESET) rdy[i] |=> !rdy[i])
            else $error("Bank rdy held longer than one cycle");
    end

    assert property (@(posedge clk_sys) disable iff (RESET) prog_rdy |=> !prog_rdy)
        else $error("prog_rdy held longer than one cycle");

    // Ack trails the blocked grant by one edge
    assert property (@(posedge clk_sys) disable iff (RESET) downloading |=> (ack == '0))
        else $error("Bank acked during download");

    ////////////////////////////////////////
    // PLL reset length
    ////////////////////////////////////////
    assert property (@(posedge clk_sys) disable iff (RESET)
        $fell(pll_rst) |-> (hold_len == $bits(hold_len)'(LOCK_HOLD_CYCLES)))
        else $error("pll_rst pulse shorter than the hold time");
    assert property (@(posedge clk_sys) disable iff (RESET)
        pll_rst |-> (hold_len < $bits(hold_len)'(LOCK_HOLD_CYCLES)))
        else $error("pll_rst pulse longer than the hold time");

endmodule

bind frame_top frame_checker u_frame_checker (
    .clk_sys     (clk_sys),
    .RESET       (RESET),
    .downloading (downloading),
    .ack         ({ba3_ack, ba2_ack, ba1_ack, ba0_ack}),
    .rdy         ({ba3_rdy, ba2_rdy, ba1_rdy, ba0_rdy}),
    .prog_rdy    (prog_rdy),
    .pll_rst     (pll_rst)
);

// ==== sim/frame_tb.sv ====
// Testbench with clock, reset, LCG, access table, shadow memory, checks and watchdog
`timescale 1ns/1ns

module frame_tb
    import frame_pkg::*;
();

    typedef enum logic [2:0] {OP_PROG, OP_READ, OP_WRITE, OP_READ_ALL, OP_LOCK_LOSS} op_e;

    typedef struct packed {
        op_e                               op;
        logic [BANK_W-1:0]                 bank;
        logic [ADDR_W-1:0]                 addr;
        logic [DATA_W-1:0]                 data;
        logic [MASK_W-1:0]                 mask;
        logic [BANK_COUNT-1:0][DATA_W-1:0] exp_data;
    } row_t;

    logic                              clk_sys;
    logic                              RESET;
    logic                              pll_locked;
    logic                              rst_req;
    logic                              downloading;
    logic                              prog_we;
    logic [ADDR_W-1:0]                 prog_addr;
    logic [BANK_W-1:0]                 prog_ba;
    logic [DATA_W-1:0]                 prog_data;
    logic [MASK_W-1:0]                 prog_mask;
    logic [BANK_COUNT-1:0]             rd;
    logic                              ba0_wr;
    logic [BANK_COUNT-1:0][ADDR_W-1:0] ba_addr;
    logic [DATA_W-1:0]                 ba0_din;
    logic [MASK_W-1:0]                 ba0_din_m;
    logic                              pll_rst;
    logic                              game_rst;
    logic                              prog_rdy;
    logic [BANK_COUNT-1:0]             ack;
    logic [BANK_COUNT-1:0]             rdy;
    logic [DATA_W-1:0]                 sdram_dout;

    row_t              rows [$];
    logic              rows_built = 1'b0;
    logic [31:0]       lcg_state  = 32'hd4cdc2da;
    logic [DATA_W-1:0] shadow [BANK_COUNT][1 << STORE_AW];

    frame_top i_frame_top (
        .clk_sys (clk_sys), .RESET (RESET), .pll_locked (pll_locked), .rst_req (rst_req),
        .downloading (downloading), .prog_we (prog_we), .prog_addr (prog_addr),
        .prog_ba (prog_ba), .prog_data (prog_data), .prog_mask (prog_mask),
        .ba0_rd (rd[0]), .ba0_wr (ba0_wr), .ba0_addr (ba_addr[0]),
        .ba0_din (ba0_din), .ba0_din_m (ba0_din_m),
        .ba1_rd (rd[1]), .ba1_addr (ba_addr[1]),
        .ba2_rd (rd[2]), .ba2_addr (ba_addr[2]),
        .ba3_rd (rd[3]), .ba3_addr (ba_addr[3]),
        .pll_rst (pll_rst), .game_rst (game_rst), .prog_rdy (prog_rdy),
        .ba0_ack (ack[0]), .ba1_ack (ack[1]), .ba2_ack (ack[2]), .ba3_ack (ack[3]),
        .ba0_rdy (rdy[0]), .ba1_rdy (rdy[1]), .ba2_rdy (rdy[2]), .ba3_rdy (rdy[3]),
        .sdram_dout (sdram_dout)
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // A set mask bit keeps the old byte
    function automatic logic [DATA_W-1:0] merge_word(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_data,
                                                     input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] merged;
        merged = new_data;
        if (mask[0]) merged[7:0] = old_word[7:0];
        if (mask[1]) merged[15:8] = old_word[15:8];
        return merged;
    endfunction

    function automatic void add_row(input op_e op, input int bank,
                                    input logic [ADDR_W-1:0] addr, input logic [MASK_W-1:0] mask);
        row_t        r;
        logic [31:0] rnd;
        r      = '0;
        r.op   = op;
        r.bank = BANK_W'(bank);
        r.addr = addr;
        r.mask = mask;
        rnd    = lcg_next();
        r.data = rnd[31:16];
        if (op == OP_PROG || op == OP_WRITE) begin
            shadow[bank][addr[STORE_AW-1:0]] =
                merge_word(shadow[bank][addr[STORE_AW-1:0]], r.data, mask);
        end
        for (int b = 0; b < BANK_COUNT; b++) begin
            r.exp_data[b] = shadow[b][addr[STORE_AW-1:0]];
        end
        rows.push_back(r);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    ////////////////////////////////////////
    // Operations
    ////////////////////////////////////////
    task automatic prog_write(input row_t r);
        int waited;
        waited      = 0;
        downloading = 1'b1;
        prog_we     = 1'b1;
        prog_ba     = r.bank;
        prog_addr   = r.addr;
        prog_data   = r.data;
        prog_mask   = r.mask;
        next_cycle();
        while (!prog_rdy) begin
            waited++;
            if (waited > 300) fail_run("Download write never got prog_rdy");
            next_cycle();
        end
        prog_we     = 1'b0;
        downloading = 1'b0;
    endtask

    // Requests on the selected banks, optionally held off by a download window first
    task automatic serve_banks(input logic [BANK_COUNT-1:0] sel, input logic is_write,
                               input logic hold_dl, input row_t r);
        logic [BANK_COUNT-1:0] got_ack;
        logic [BANK_COUNT-1:0] got_rdy;
        int                    waited;
        got_ack = '0;
        got_rdy = '0;
        waited  = 0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            if (sel[b]) ba_addr[b] = r.addr;
        end
        ba0_din     = r.data;
        ba0_din_m   = r.mask;
        downloading = hold_dl;
        rd          = is_write ? '0 : sel;
        ba0_wr      = is_write;
        if (hold_dl) begin
            repeat (4) begin
                next_cycle();
                check_value("bank ack during download", 32'(ack), 32'd0);
            end
            downloading = 1'b0;
        end
        while (got_rdy != sel) begin
            next_cycle();
            waited++;
            if (waited > 300) fail_run("Bank request never completed");
            if (|(ack & (~sel | got_ack))) fail_run("Bank ack unrequested or repeated");
            if (|(rdy & (~sel | got_rdy))) fail_run("Bank rdy unrequested or repeated");
            if (|(rdy & ~got_ack)) fail_run("Bank rdy came before its ack");
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (rdy[b]) begin
                    check_value($sformatf("sdram_dout bank %0d", b), 32'(sdram_dout),
                                32'(r.exp_data[b]));
                end
            end
            got_ack = got_ack | ack;
            got_rdy = got_rdy | rdy;
            rd      = rd & ~ack;
            if (ack[0]) ba0_wr = 1'b0;
        end
    endtask

    task automatic lock_loss();
        int high_cycles;
        high_cycles = 0;
        pll_locked  = 1'b0;
        next_cycle();
        pll_locked = 1'b1;
        while (pll_rst) begin
            check_value("game_rst", 32'(game_rst), 32'd1);
            high_cycles++;
            if (high_cycles > 300) fail_run("pll_rst never dropped");
            next_cycle();
        end
        check_value("pll_rst cycles", 32'(high_cycles), 32'(LOCK_HOLD_CYCLES));
        next_cycle();
        check_value("game_rst", 32'(game_rst), 32'd0);
        rst_req = 1'b1;
        next_cycle();
        check_value("game_rst", 32'(game_rst), 32'd1);
        rst_req = 1'b0;
        next_cycle();
        check_value("game_rst", 32'(game_rst), 32'd0);
    endtask

    ////////////////////////////////////////
    // Table and main sequence
    ////////////////////////////////////////
    task automatic build_rows();
        add_row(OP_PROG, 0, 22'h000010, 2'b00);
        add_row(OP_PROG, 1, 22'h000020, 2'b00);
        add_row(OP_PROG, 2, 22'h000030, 2'b00);
        add_row(OP_PROG, 3, 22'h0000ff, 2'b00);
        // Aliases bank 1 word 0x20, low byte kept
        add_row(OP_PROG, 1, 22'h000120, 2'b01);
        add_row(OP_READ, 0, 22'h000010, 2'b00);
        add_row(OP_READ, 1, 22'h3fff20, 2'b00);
        add_row(OP_READ, 2, 22'h000130, 2'b00);
        add_row(OP_READ, 3, 22'h2000ff, 2'b00);
        add_row(OP_WRITE, 0, 22'h000010, 2'b01);
        add_row(OP_READ, 0, 22'h000110, 2'b00);
        add_row(OP_WRITE, 0, 22'h000077, 2'b00);
        add_row(OP_READ, 0, 22'h000077, 2'b00);
        for (int b = 0; b < BANK_COUNT; b++) begin
            add_row(OP_PROG, b, 22'h000055, 2'b00);
        end
        add_row(OP_WRITE, 0, 22'h000055, 2'b10);
        add_row(OP_READ_ALL, 0, 22'h000055, 2'b00);
        add_row(OP_LOCK_LOSS, 0, 22'h000000, 2'b00);
        add_row(OP_READ, 3, 22'h0000ff, 2'b00);
    endtask

    initial begin
        RESET       = 1'b1;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_ba     = '0;
        prog_data   = '0;
        prog_mask   = '0;
        rd          = '0;
        ba0_wr      = 1'b0;
        ba_addr     = '0;
        ba0_din     = '0;
        ba0_din_m   = '0;
        build_rows();
        rows_built = 1'b1;
        repeat (5) @(posedge clk_sys);
        #1;
        check_value("ack", 32'(ack), 32'd0);
        check_value("rdy", 32'(rdy), 32'd0);
        check_value("prog_rdy", 32'(prog_rdy), 32'd0);
        check_value("pll_rst", 32'(pll_rst), 32'd0);
        check_value("game_rst", 32'(game_rst), 32'd1);
        RESET = 1'b0;
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_PROG:      prog_write(rows[i]);
                OP_READ:      serve_banks(4'b0001 << rows[i].bank, 1'b0, 1'b0, rows[i]);
                OP_WRITE:     serve_banks(4'b0001, 1'b1, 1'b0, rows[i]);
                OP_READ_ALL:  serve_banks(4'b1111, 1'b0, 1'b1, rows[i]);
                default:      lock_loss();
            endcase
        end
        $display("all tests passed");
        $finish;
    end

    // Bound of 300 cycles per row plus reset, at 4 ns per cycle
    initial begin
        int unsigned limit_ns;
        wait (rows_built);
        limit_ns = (rows.size() + 2) * 300 * 4;
        #(limit_ns);
        fail_run("Watchdog expired before the table finished");
    end

endmodule

// ==== verilog.f ====
design/frame_pkg.sv
design/bank_slot.sv
design/access_ctrl.sv
design/rom_store.sv
design/pll_supervisor.sv
design/frame_top.sv
sim/frame_checker.sv
sim/frame_tb.sv
